// File: hw/memModel_cfg.svh
// Settings for the simulation-only memory latency model
// MEM_RAND_SEED must be nonzero, MEM_FIXED_LATENCY and MEM_LATENCY_RANGE at least 1
`ifndef MEM_MODEL_CFG_SVH
`define MEM_MODEL_CFG_SVH

// Byte address width, which also sizes the array
`define MEM_ADDR_BITS 10
`define MEM_DATA_BITS 32
`define MEM_TAG_BITS 4

// Entries in the random-mode request queue
`define MEM_QUEUE_DEPTH 8

// 1 selects random latency, 0 selects the fixed shift register
`define MEM_LATENCY_RANDOM 1

// Shift stages in fixed mode
`define MEM_FIXED_LATENCY 4

// Random wait is the generator value modulo this range
`define MEM_LATENCY_RANGE 6
`define MEM_RAND_SEED 32'h2545_F491

`endif

// File: hw/memModelPkg.sv
// Types shared by the memory latency model
// Request word width follows the address, tag and data widths in the config header
`include "memModel_cfg.svh"

package memModelPkg;

    typedef enum logic {
        KindRead  = 1'b0,
        KindWrite = 1'b1
    } RequestKind;

    // One request word, decoded as a read or as a write
    typedef union packed {
        struct packed {
            RequestKind                kind;
            logic [`MEM_TAG_BITS-1:0]  tag;
            logic [`MEM_ADDR_BITS-3:0] wordAddr;
            // Reads carry no payload
            logic [`MEM_DATA_BITS-1:0] pad;
        } rd;
        struct packed {
            RequestKind                kind;
            logic [`MEM_TAG_BITS-1:0]  tag;
            logic [`MEM_ADDR_BITS-3:0] wordAddr;
            logic [`MEM_DATA_BITS-1:0] wrData;
        } wr;
    } MemRequest;

endpackage

// File: hw/memReqDecode.sv
// Command decode; only word-aligned byte addresses are accepted
// A misaligned command is dropped and only reported through cmdError
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memReqDecode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmdValid,
    input  logic                          cmdWrite,
    input  logic [`MEM_ADDR_BITS-1:0]     cmdAddr,
    input  logic [`MEM_DATA_BITS-1:0]     cmdData,
    input  logic [`MEM_TAG_BITS-1:0]      cmdTag,
    output logic                          pushValid,
    output memModelPkg::MemRequest        pushReq,
    output logic                          cmdError
);

    logic                   aligned;
    memModelPkg::MemRequest nextReq;

    assign aligned = (cmdAddr[1:0] == 2'b00);

    // Pack the command into the view matching its kind
    always_comb begin
        if (cmdWrite) begin
            nextReq.wr.kind     = memModelPkg::KindWrite;
            nextReq.wr.tag      = cmdTag;
            nextReq.wr.wordAddr = cmdAddr[`MEM_ADDR_BITS-1:2];
            nextReq.wr.wrData   = cmdData;
        end else begin
            nextReq.rd.kind     = memModelPkg::KindRead;
            nextReq.rd.tag      = cmdTag;
            nextReq.rd.wordAddr = cmdAddr[`MEM_ADDR_BITS-1:2];
            nextReq.rd.pad      = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pushValid <= 1'b0;
            cmdError  <= 1'b0;
        end else begin
            pushValid <= cmdValid && aligned;
            cmdError  <= cmdValid && !aligned;
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid && aligned) begin
            pushReq <= nextReq;
        end
    end

endmodule

// File: hw/memLatencySim.sv
// Delays request words by a fixed or pseudo-random number of cycles, in order
// In random mode full already counts the request one cycle behind in decode
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memLatencySim (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pushValid,
    input  memModelPkg::MemRequest pushReq,
    output logic                   full,
    output logic                   outValid,
    output memModelPkg::MemRequest outReq
);

    if (`MEM_LATENCY_RANDOM != 0) begin : randomPath
        localparam int Depth     = `MEM_QUEUE_DEPTH;
        localparam int PtrBits   = (Depth > 1) ? $clog2(Depth) : 1;
        localparam int CountBits = $clog2(Depth + 1);
        localparam int WaitBits  = $clog2(`MEM_LATENCY_RANGE + 1);

        memModelPkg::MemRequest queueMem [Depth];
        logic [PtrBits-1:0]     headPtr;
        logic [PtrBits-1:0]     tailPtr;
        logic [CountBits-1:0]   occupancy;
        logic [WaitBits-1:0]    waitCnt;
        logic [WaitBits-1:0]    waitTarget;
        logic [31:0]            randState;
        logic [31:0]            randNext;
        logic                   empty;
        logic                   pop;

        // Circular increment for a depth that need not be a power of two
        function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
            if (ptr == PtrBits'(Depth - 1)) begin
                return '0;
            end
            return ptr + 1'b1;
        endfunction

        assign empty      = (occupancy == '0);
        assign waitTarget = WaitBits'(randState % `MEM_LATENCY_RANGE);
        // Head leaves once it has waited its drawn number of cycles
        assign pop        = !empty && (waitCnt == waitTarget);

        // xorshift32
        always_comb begin
            randNext = randState ^ (randState << 13);
            randNext = randNext ^ (randNext >> 17);
            randNext = randNext ^ (randNext << 5);
        end

        always_ff @(posedge clk) begin
            if (pushValid) begin
                queueMem[tailPtr] <= pushReq;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                headPtr   <= '0;
                tailPtr   <= '0;
                occupancy <= '0;
                waitCnt   <= '0;
                randState <= `MEM_RAND_SEED;
            end else begin
                if (pushValid) begin
                    tailPtr <= nextPtr(tailPtr);
                end
                if (pop) begin
                    headPtr <= nextPtr(headPtr);
                end
                case ({pushValid, pop})
                    2'b10:   occupancy <= occupancy + 1'b1;
                    2'b01:   occupancy <= occupancy - 1'b1;
                    default: occupancy <= occupancy;
                endcase
                // Wait restarts for the entry that becomes head next cycle
                if (pop) begin
                    waitCnt   <= '0;
                    randState <= randNext;
                end else if (!empty) begin
                    waitCnt <= waitCnt + 1'b1;
                end
            end
        end

        assign full     = (int'(occupancy) + int'(pushValid)) >= Depth;
        assign outValid = pop;
        assign outReq   = queueMem[headPtr];
    end else begin : fixedPath
        localparam int Latency = `MEM_FIXED_LATENCY;

        logic [Latency-1:0]     stageValid;
        memModelPkg::MemRequest stageReq [Latency];

        always_ff @(posedge clk) begin
            if (rst) begin
                stageValid <= '0;
            end else begin
                stageValid[0] <= pushValid;
                for (int i = 1; i < Latency; i++) begin
                    stageValid[i] <= stageValid[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            stageReq[0] <= pushReq;
            for (int i = 1; i < Latency; i++) begin
                stageReq[i] <= stageReq[i-1];
            end
        end

        // Every slot moves each cycle, so the command side is never held off
        assign full     = 1'b0;
        assign outValid = stageValid[Latency-1];
        assign outReq   = stageReq[Latency-1];
    end

endmodule

// File: hw/memArray.sv
// Word-addressed storage array that is cleared at reset
// Responses are registered and cannot be stalled by the consumer
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memArray (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      outValid,
    input  memModelPkg::MemRequest    outReq,
    output logic                      respValid,
    output logic                      respWrite,
    output logic [`MEM_TAG_BITS-1:0]  respTag,
    output logic [`MEM_DATA_BITS-1:0] respData
);

    localparam int Words = 1 << (`MEM_ADDR_BITS - 2);

    logic [`MEM_DATA_BITS-1:0] mem [Words];
    logic                      isWrite;

    assign isWrite = (outReq.wr.kind == memModelPkg::KindWrite);

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
            for (int i = 0; i < Words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            respValid <= outValid;
            if (outValid && isWrite) begin
                mem[outReq.wr.wordAddr] <= outReq.wr.wrData;
            end
        end
    end

    // Write data is echoed back in the response
    always_ff @(posedge clk) begin
        if (outValid) begin
            respWrite <= isWrite;
            if (isWrite) begin
                respTag  <= outReq.wr.tag;
                respData <= outReq.wr.wrData;
            end else begin
                respTag  <= outReq.rd.tag;
                respData <= mem[outReq.rd.wordAddr];
            end
        end
    end

endmodule

// File: hw/memSubsystem.sv
// Memory model top; cmdValid must stay low while busy is high
// Latency mode and sizes come from the config header
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memSubsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmdValid,
    input  logic                      cmdWrite,
    input  logic [`MEM_ADDR_BITS-1:0] cmdAddr,
    input  logic [`MEM_DATA_BITS-1:0] cmdData,
    input  logic [`MEM_TAG_BITS-1:0]  cmdTag,
    output logic                      busy,
    output logic                      cmdError,
    output logic                      respValid,
    output logic                      respWrite,
    output logic [`MEM_TAG_BITS-1:0]  respTag,
    output logic [`MEM_DATA_BITS-1:0] respData
);

    logic                   pushValid;
    memModelPkg::MemRequest pushReq;
    logic                   outValid;
    memModelPkg::MemRequest outReq;

    memReqDecode decode (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdWrite  (cmdWrite),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdTag    (cmdTag),
        .pushValid (pushValid),
        .pushReq   (pushReq),
        .cmdError  (cmdError)
    );

    memLatencySim latency (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushReq   (pushReq),
        .full      (busy),
        .outValid  (outValid),
        .outReq    (outReq)
    );

    memArray array (
        .clk       (clk),
        .rst       (rst),
        .outValid  (outValid),
        .outReq    (outReq),
        .respValid (respValid),
        .respWrite (respWrite),
        .respTag   (respTag),
        .respData  (respData)
    );

endmodule

// File: verification/memSubsystem_checker.sv
// Protocol assertions bound into memSubsystem
// Reset checks assume reset is held for at least two cycles
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memSubsystemChecker (
    input logic                      clk,
    input logic                      rst,
    input logic                      cmdValid,
    input logic [`MEM_ADDR_BITS-1:0] cmdAddr,
    input logic                      busy,
    input logic                      cmdError,
    input logic                      respValid
);

    // Number of assertion failures so far
    int violations = 0;

    noCmdWhileBusy: assert property (@(posedge clk) disable iff (rst) !(cmdValid && busy))
        else begin
            $error("cmdValid asserted while busy is high");
            violations++;
        end

    // Quiet during reset and for the cycle after it
    quietAfterReset: assert property (@(posedge clk)
        ($past(rst) || $past(rst, 2)) |-> (!respValid && !cmdError))
        else begin
            $error("respValid or cmdError high around reset");
            violations++;
        end

    noErrorWhenAligned: assert property (@(posedge clk) disable iff (rst)
        (cmdValid && cmdAddr[1:0] == 2'b00) |=> !cmdError)
        else begin
            $error("cmdError after an aligned command");
            violations++;
        end

    errorWhenMisaligned: assert property (@(posedge clk) disable iff (rst)
        (cmdValid && cmdAddr[1:0] != 2'b00) |=> cmdError)
        else begin
            $error("No cmdError after a misaligned command");
            violations++;
        end

endmodule

bind memSubsystem memSubsystemChecker protocolCheck (
    .clk       (clk),
    .rst       (rst),
    .cmdValid  (cmdValid),
    .cmdAddr   (cmdAddr),
    .busy      (busy),
    .cmdError  (cmdError),
    .respValid (respValid)
);

// File: verification/memSubsystemTb.sv
// Random traffic against a shadow memory with responses checked in command order
// Address window needs at least 6 address bits and data of at most 32 bits
`timescale 1ns/1ps
`include "memModel_cfg.svh"

module memSubsystemTb;

    localparam time HalfPeriod   = 20;
    localparam time ClkPeriod    = 40;
    localparam time LatencyBound = time'(`MEM_QUEUE_DEPTH * `MEM_LATENCY_RANGE + 3);
    localparam int  BurstCount   = 24;
    localparam int  RandomCount  = 150;
    localparam int  NumCommands  = 4 + BurstCount + RandomCount;
    localparam int  CycleLimit   = NumCommands * (`MEM_QUEUE_DEPTH * `MEM_LATENCY_RANGE + 4);
    localparam int  Words        = 1 << (`MEM_ADDR_BITS - 2);

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      cmdValid;
    logic                      cmdWrite;
    logic [`MEM_ADDR_BITS-1:0] cmdAddr;
    logic [`MEM_DATA_BITS-1:0] cmdData;
    logic [`MEM_TAG_BITS-1:0]  cmdTag;
    logic                      busy;
    logic                      cmdError;
    logic                      respValid;
    logic                      respWrite;
    logic [`MEM_TAG_BITS-1:0]  respTag;
    logic [`MEM_DATA_BITS-1:0] respData;

    logic [`MEM_DATA_BITS-1:0] shadowMem [Words];
    logic                      expWrite [$];
    logic [`MEM_TAG_BITS-1:0]  expTag [$];
    logic [`MEM_DATA_BITS-1:0] expData [$];
    time                       expTime [$];
    time                       errTime [$];
    logic [15:0]               lfsrState = 16'd22;
    int                        cycleCount = 0;
    int                        issuedCount = 0;
    int                        respSeen = 0;
    logic                      lastAccepted = 1'b0;
    logic                      busySeen = 1'b0;

    memSubsystem dut (.*);

    always #(HalfPeriod) clk = ~clk;

    task automatic failRun();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            failRun();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    // Updates the shadow memory and queues the expected response or cmdError pulse
    function automatic void applyReference(input logic wr,
                                           input logic [`MEM_ADDR_BITS-1:0] addr,
                                           input logic [`MEM_DATA_BITS-1:0] data,
                                           input logic [`MEM_TAG_BITS-1:0] tag, input time t);
        if (addr[1:0] != 2'b00) begin
            errTime.push_back(t);
        end else begin
            if (wr) begin
                shadowMem[addr[`MEM_ADDR_BITS-1:2]] = data;
            end
            expWrite.push_back(wr);
            expTag.push_back(tag);
            expData.push_back(shadowMem[addr[`MEM_ADDR_BITS-1:2]]);
            expTime.push_back(t);
        end
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            cmdValid <= 1'b0;
            lastAccepted = 1'b0;
        end
    endtask

    // busy seen at the negedge lags one cycle, so a back-to-back push also needs queue room
    task automatic sendCommand(input logic wr, input logic [`MEM_ADDR_BITS-1:0] addr,
                               input logic [`MEM_DATA_BITS-1:0] data,
                               input logic [`MEM_TAG_BITS-1:0] tag);
        @(negedge clk);
        while (busy || (lastAccepted && (issuedCount - respSeen) >= `MEM_QUEUE_DEPTH)) begin
            @(posedge clk);
            cmdValid <= 1'b0;
            lastAccepted = 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        cmdValid <= 1'b1;
        cmdWrite <= wr;
        cmdAddr  <= addr;
        cmdData  <= data;
        cmdTag   <= tag;
        lastAccepted = (addr[1:0] == 2'b00);
        if (lastAccepted) begin
            issuedCount++;
        end
        applyReference(wr, addr, data, tag, $time);
    endtask

    task automatic sendRandomCommand();
        logic [31:0]               bits;
        logic                      wr;
        logic [`MEM_ADDR_BITS-1:0] addr;
        takeBits(1, bits);
        wr = bits[0];
        takeBits(4, bits);
        addr = '0;
        addr[5:2] = bits[3:0];
        // About one command in sixteen is misaligned
        takeBits(4, bits);
        if (bits[3:0] == 4'd0) begin
            takeBits(2, bits);
            addr[1:0] = (bits[1:0] == 2'b00) ? 2'b11 : bits[1:0];
        end
        takeBits(`MEM_DATA_BITS, bits);
        sendWithRandomTag(wr, addr, bits[`MEM_DATA_BITS-1:0]);
    endtask

    task automatic sendWithRandomTag(input logic wr, input logic [`MEM_ADDR_BITS-1:0] addr,
                                     input logic [`MEM_DATA_BITS-1:0] data);
        logic [31:0] bits;
        takeBits(`MEM_TAG_BITS, bits);
        sendCommand(wr, addr, data, bits[`MEM_TAG_BITS-1:0]);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (respValid) begin
            respSeen <= respSeen + 1;
        end
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles, %0d responses never arrived", cycleCount,
                     expWrite.size());
            failRun();
        end
    end

    always @(negedge clk) begin : compareResponses
        logic errDue;
        time  latency;
        if (busy === 1'b1) begin
            busySeen = 1'b1;
        end
        if (dut.protocolCheck.violations != 0) begin
            $display("Protocol checker saw %0d assertion failures",
                     dut.protocolCheck.violations);
            failRun();
        end
        if (!rst) begin
            errDue = (errTime.size() != 0) && (errTime[0] + ClkPeriod + HalfPeriod == $time);
            checkValue(64'(cmdError), 64'(errDue), "cmdError");
            if (errDue) begin
                void'(errTime.pop_front());
            end
            if (respValid && expWrite.size() == 0) begin
                $display("Response at %0d ns with no command outstanding", $time);
                failRun();
            end else if (respValid) begin
                latency = ($time - HalfPeriod - expTime.pop_front()) / ClkPeriod;
                checkValue(64'(respWrite), 64'(expWrite.pop_front()), "respWrite");
                checkValue(64'(respTag), 64'(expTag.pop_front()), "respTag");
                checkValue(64'(respData), 64'(expData.pop_front()), "respData");
                if (`MEM_LATENCY_RANDOM != 0) begin
                    checkValue(64'(latency <= LatencyBound), 64'd1, "latency within bound");
                end else begin
                    checkValue(latency, time'(`MEM_FIXED_LATENCY + 2), "fixed latency");
                end
            end
        end
    end

    initial begin
        logic [31:0] bits;
        for (int i = 0; i < Words; i++) begin
            shadowMem[i] = '0;
        end
        rst      <= 1'b1;
        cmdValid <= 1'b0;
        cmdWrite <= 1'b0;
        cmdAddr  <= '0;
        cmdData  <= '0;
        cmdTag   <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Read of an unwritten word, write, read back and a misaligned access
        sendCommand(1'b0, `MEM_ADDR_BITS'(36), '0, `MEM_TAG_BITS'(1));
        sendCommand(1'b1, `MEM_ADDR_BITS'(36), `MEM_DATA_BITS'(32'hC0DE_1234),
                    `MEM_TAG_BITS'(2));
        sendCommand(1'b0, `MEM_ADDR_BITS'(36), '0, `MEM_TAG_BITS'(3));
        sendCommand(1'b0, `MEM_ADDR_BITS'(38), '0, `MEM_TAG_BITS'(4));
        // No gaps here so the queue fills and busy rises
        repeat (BurstCount) sendRandomCommand();
        repeat (RandomCount) begin
            sendRandomCommand();
            takeBits(2, bits);
            if (bits[1:0] == 2'b00) begin
                takeBits(2, bits);
                idleCycles(int'(bits[1:0]) + 1);
            end
        end
        while (expWrite.size() != 0 || errTime.size() != 0) begin
            idleCycles(1);
        end
        idleCycles(4);
        if (`MEM_LATENCY_RANDOM != 0 && !busySeen) begin
            $display("Busy never rose during the back-to-back burst");
            failRun();
        end else if (dut.protocolCheck.violations != 0) begin
            $display("Protocol checker saw %0d assertion failures",
                     dut.protocolCheck.violations);
            failRun();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: memSubsystem.f
+incdir+hw
hw/memModelPkg.sv
hw/memReqDecode.sv
hw/memLatencySim.sv
hw/memArray.sv
hw/memSubsystem.sv
verification/memSubsystem_checker.sv
verification/memSubsystemTb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := memSubsystemTb
FILELIST   := memSubsystem.f
OBJDIR     := obj_dir
PASS_MSG   := Verification passed

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
